// ==== hdl/fetch_pkg.sv ====
package fetch_pkg;

    // ============================================================
    // widths
    // ============================================================

    localparam int HALF_W = 16;                     // one instruction parcel

    typedef logic [31:0]       addr_t;              // byte address
    typedef logic [29:0]       word_addr_t;         // byte address without bits 1:0
    typedef logic [HALF_W-1:0] half_t;              // 16-bit parcel
    typedef logic [31:0]       instr_t;             // issued instruction

    // ============================================================
    // prefetch buffer entry
    // ============================================================

    // bit HALF_W is the bus error flag, the rest is the parcel
    typedef logic [HALF_W:0]   ipb_entry_t;

    // ============================================================
    // fetch FSM
    // ============================================================

    typedef enum logic [1:0] {
        IF_RESTART = 2'b00,                         // load new fetch address
        IF_REQUEST = 2'b01,                         // wait for room, then request
        IF_PENDING = 2'b10                          // wait for ack or err
    } if_state_t;

endpackage

// ==== hdl/fetch_ctrl.sv ====
`timescale 1ns/1ns

module fetch_ctrl #(
    parameter fetch_pkg::addr_t BOOT_ADDR = 32'h0000_0000    // fetch start after reset
) (
    input  logic                  i_clk,
    input  logic                  i_rstn,
    // redirect from the execute side
    input  logic                  i_redirect,                // one-cycle pulse
    input  fetch_pkg::addr_t      i_redirect_pc,             // halfword aligned
    // bus response
    input  logic                  i_bus_rsp_ack,             // read done
    input  logic                  i_bus_rsp_err,             // read failed
    input  fetch_pkg::instr_t     i_bus_rsp_data,
    // prefetch buffer status
    input  logic [1:0]            i_lane_free,               // [0] lo lane, [1] hi lane
    // bus request
    output logic                  o_bus_req_re,              // one-cycle read strobe
    output fetch_pkg::addr_t      o_bus_req_addr,            // always word aligned
    // lane writes
    output logic [1:0]            o_lane_we,
    output fetch_pkg::ipb_entry_t o_lane_wdata_lo,
    output fetch_pkg::ipb_entry_t o_lane_wdata_hi,
    // restart control
    output logic                  o_flush,                   // empties lanes, resets aligner
    output logic                  o_start_hi                 // first parcel in hi lane
);

    import fetch_pkg::*;

    if_state_t  if_state;          // fetch FSM
    word_addr_t if_pc;             // word currently fetched
    logic       if_unaligned;      // restart target at odd halfword
    logic       if_restart;        // flush pending until IF_RESTART
    addr_t      restart_pc;        // latched restart target
    addr_t      restart_src;       // target valid in this cycle
    logic       if_resp;           // response for our request

    // ============================================================
    // restart address
    // ============================================================

    // a redirect in the current cycle wins over the latched one
    assign restart_src = i_redirect ? i_redirect_pc : restart_pc;
    assign o_start_hi  = restart_src[1];                     // odd half -> hi lane first

    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            restart_pc <= BOOT_ADDR;                         // boot counts as a restart
        end else if (i_redirect) begin
            restart_pc <= i_redirect_pc;
        end
    end

    // ============================================================
    // fetch FSM
    // ============================================================

    assign if_resp = (if_state == IF_PENDING) && (i_bus_rsp_ack || i_bus_rsp_err);

    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            if_state     <= IF_RESTART;
            if_restart   <= 1'b1;                            // flush once after reset
            if_unaligned <= 1'b0;
            if_pc        <= '0;
        end else begin
            if (if_state == IF_RESTART) begin
                if_restart <= 1'b0;                          // restart consumed
            end else if (i_redirect) begin
                if_restart <= 1'b1;
            end

            case (if_state)
                IF_RESTART: begin
                    if_pc        <= restart_src[31:2];       // word of the target
                    if_unaligned <= restart_src[1];
                    if_state     <= IF_REQUEST;
                end
                IF_REQUEST: begin
                    if (o_flush) begin
                        if_state <= IF_RESTART;              // no request, restart first
                    end else if (i_lane_free == 2'b11) begin
                        if_state <= IF_PENDING;              // request goes out now
                    end
                end
                IF_PENDING: begin
                    if (if_resp) begin
                        if_pc        <= if_pc + 30'd1;       // next word
                        if_unaligned <= 1'b0;
                        if_state     <= o_flush ? IF_RESTART : IF_REQUEST;
                    end
                end
                default: begin
                    if_state <= IF_RESTART;
                end
            endcase
        end
    end

    assign o_flush = if_restart || i_redirect;

    // ============================================================
    // bus request and lane writes
    // ============================================================

    assign o_bus_req_re   = (if_state == IF_REQUEST) && (i_lane_free == 2'b11) && !o_flush;
    assign o_bus_req_addr = {if_pc, 2'b00};

    assign o_lane_wdata_lo = {i_bus_rsp_err, i_bus_rsp_data[HALF_W-1:0]};
    assign o_lane_wdata_hi = {i_bus_rsp_err, i_bus_rsp_data[2*HALF_W-1:HALF_W]};

    // lo half of the first word is skipped after an odd restart
    assign o_lane_we[0] = if_resp && !if_unaligned && i_lane_free[0];
    assign o_lane_we[1] = if_resp && i_lane_free[1];

endmodule

// ==== hdl/ipb_lane_fifo.sv ====
`timescale 1ns/1ns

module ipb_lane_fifo #(
    parameter int DEPTH = 4                                  // entries, power of two, >= 2
) (
    input  logic                  i_clk,
    input  logic                  i_rstn,
    input  logic                  i_clear,                   // sync empty, beats write
    input  logic                  i_we,
    input  logic                  i_re,
    input  fetch_pkg::ipb_entry_t i_wdata,
    output logic                  o_free,                    // at least one slot left
    output logic                  o_avail,                   // head entry valid
    output fetch_pkg::ipb_entry_t o_rdata                    // head, combinational
);

    import fetch_pkg::*;

    localparam int AW = $clog2(DEPTH);                       // index bits

    ipb_entry_t  mem [DEPTH];                                // parcel storage
    logic [AW:0] wr_ptr;                                     // msb is the wrap bit
    logic [AW:0] rd_ptr;
    logic        full;
    logic        empty;
    logic        do_we;                                      // write accepted
    logic        do_re;                                      // read accepted

    // ============================================================
    // status
    // ============================================================

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    assign do_we = i_we && !full;                            // drop write when full
    assign do_re = i_re && !empty;                           // drop read when empty

    assign o_free  = !full;
    assign o_avail = !empty;

    // ============================================================
    // pointers
    // ============================================================

    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else if (i_clear) begin
            wr_ptr <= '0;                                    // clear beats write
            rd_ptr <= '0;
        end else begin
            if (do_we) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_re) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // ============================================================
    // storage
    // ============================================================

    always_ff @(posedge i_clk) begin
        if (do_we && !i_clear) begin
            mem[wr_ptr[AW-1:0]] <= i_wdata;
        end
    end

    assign o_rdata = mem[rd_ptr[AW-1:0]];                    // head of queue

endmodule

// ==== hdl/issue_align.sv ====
`timescale 1ns/1ns

module issue_align (
    input  logic                  i_clk,
    input  logic                  i_rstn,
    // restart
    input  logic                  i_flush,                   // drop partial state
    input  logic                  i_start_hi,                // first parcel in hi lane
    // lane heads
    input  logic                  i_lo_avail,
    input  logic                  i_hi_avail,
    input  fetch_pkg::ipb_entry_t i_lo_rdata,
    input  fetch_pkg::ipb_entry_t i_hi_rdata,
    output logic                  o_lo_re,                   // pop lo lane
    output logic                  o_hi_re,                   // pop hi lane
    // issue port
    input  logic                  i_issue_ack,               // consumer takes instruction
    output logic                  o_issue_valid,
    output fetch_pkg::instr_t     o_issue_instr,
    output logic                  o_issue_ci,                // compressed, passed raw
    output logic                  o_issue_err                // bus error in a used parcel
);

    import fetch_pkg::*;

    logic       align;                                       // 0: next parcel in lo, 1: in hi
    ipb_entry_t first_ent;                                   // parcel at the issue pc
    ipb_entry_t second_ent;                                  // parcel after it
    logic       first_avail;
    logic       second_avail;
    half_t      first_half;
    half_t      second_half;
    logic       is_ci;                                       // 16-bit instruction
    logic       issue_fire;                                  // instruction retires

    // ============================================================
    // parcel select
    // ============================================================

    // with align set the lo head already belongs to the next word
    always_comb begin
        if (align) begin
            first_ent    = i_hi_rdata;
            first_avail  = i_hi_avail;
            second_ent   = i_lo_rdata;
            second_avail = i_lo_avail;
        end else begin
            first_ent    = i_lo_rdata;
            first_avail  = i_lo_avail;
            second_ent   = i_hi_rdata;
            second_avail = i_hi_avail;
        end
    end

    assign first_half  = first_ent[HALF_W-1:0];
    assign second_half = second_ent[HALF_W-1:0];

    // low bits 11 mark a 32-bit instruction
    assign is_ci = (first_half[1:0] != 2'b11);

    // ============================================================
    // issue port
    // ============================================================

    assign o_issue_valid = !i_flush && first_avail && (is_ci || second_avail);

    always_comb begin
        if (is_ci) begin
            o_issue_instr = {{HALF_W{1'b0}}, first_half};   // zero-extended, no decompress
            o_issue_err   = first_ent[HALF_W];
        end else begin
            o_issue_instr = {second_half, first_half};
            o_issue_err   = first_ent[HALF_W] || second_ent[HALF_W];
        end
    end

    assign o_issue_ci = is_ci;

    assign issue_fire = o_issue_valid && i_issue_ack;

    // ============================================================
    // lane pops
    // ============================================================

    // a 32-bit instruction takes both heads, a 16-bit one only its own
    always_comb begin
        o_lo_re = 1'b0;
        o_hi_re = 1'b0;
        if (issue_fire) begin
            if (!is_ci) begin
                o_lo_re = 1'b1;
                o_hi_re = 1'b1;
            end else if (align) begin
                o_hi_re = 1'b1;
            end else begin
                o_lo_re = 1'b1;
            end
        end
    end

    // ============================================================
    // align bit
    // ============================================================

    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            align <= 1'b0;
        end else if (i_flush) begin
            align <= i_start_hi;                             // from restart address bit 1
        end else if (issue_fire && is_ci) begin
            align <= !align;                                 // one parcel used
        end
    end

endmodule

// ==== hdl/fetch_frontend.sv ====
`timescale 1ns/1ns

module fetch_frontend #(
    parameter fetch_pkg::addr_t BOOT_ADDR = 32'h0000_0000,   // reset fetch address
    parameter int               IPB_DEPTH = 4                // entries per lane
) (
    input  logic              i_clk,
    input  logic              i_rstn,
    // redirect
    input  logic              i_redirect,
    input  fetch_pkg::addr_t  i_redirect_pc,
    // instruction bus
    output logic              o_bus_req_re,
    output fetch_pkg::addr_t  o_bus_req_addr,
    input  fetch_pkg::instr_t i_bus_rsp_data,
    input  logic              i_bus_rsp_ack,
    input  logic              i_bus_rsp_err,
    // issue
    output logic              o_issue_valid,
    output fetch_pkg::instr_t o_issue_instr,
    output logic              o_issue_ci,
    output logic              o_issue_err,
    input  logic              i_issue_ack
);

    import fetch_pkg::*;

    logic [1:0] lane_we;              // [0] lo, [1] hi
    logic [1:0] lane_free;
    ipb_entry_t lane_wdata_lo;
    ipb_entry_t lane_wdata_hi;
    logic       lo_avail;
    logic       hi_avail;
    ipb_entry_t lo_rdata;
    ipb_entry_t hi_rdata;
    logic       lo_re;
    logic       hi_re;
    logic       flush;                // lanes and aligner restart
    logic       start_hi;

    // ============================================================
    // fetch
    // ============================================================

    fetch_ctrl #(
        .BOOT_ADDR (BOOT_ADDR)
    ) u_ctrl (
        .i_clk           (i_clk),
        .i_rstn          (i_rstn),
        .i_redirect      (i_redirect),
        .i_redirect_pc   (i_redirect_pc),
        .i_bus_rsp_ack   (i_bus_rsp_ack),
        .i_bus_rsp_err   (i_bus_rsp_err),
        .i_bus_rsp_data  (i_bus_rsp_data),
        .i_lane_free     (lane_free),
        .o_bus_req_re    (o_bus_req_re),
        .o_bus_req_addr  (o_bus_req_addr),
        .o_lane_we       (lane_we),
        .o_lane_wdata_lo (lane_wdata_lo),
        .o_lane_wdata_hi (lane_wdata_hi),
        .o_flush         (flush),
        .o_start_hi      (start_hi)
    );

    // ============================================================
    // prefetch buffer, one FIFO per halfword lane
    // ============================================================

    ipb_lane_fifo #(.DEPTH(IPB_DEPTH)) lane_lo (
        .i_clk (i_clk), .i_rstn (i_rstn), .i_clear (flush),
        .i_we (lane_we[0]), .i_re (lo_re), .i_wdata (lane_wdata_lo),
        .o_free (lane_free[0]), .o_avail (lo_avail), .o_rdata (lo_rdata)
    );

    ipb_lane_fifo #(.DEPTH(IPB_DEPTH)) lane_hi (
        .i_clk (i_clk), .i_rstn (i_rstn), .i_clear (flush),
        .i_we (lane_we[1]), .i_re (hi_re), .i_wdata (lane_wdata_hi),
        .o_free (lane_free[1]), .o_avail (hi_avail), .o_rdata (hi_rdata)
    );

    // ============================================================
    // issue
    // ============================================================

    issue_align u_align (
        .i_clk         (i_clk),
        .i_rstn        (i_rstn),
        .i_flush       (flush),
        .i_start_hi    (start_hi),
        .i_lo_avail    (lo_avail),
        .i_hi_avail    (hi_avail),
        .i_lo_rdata    (lo_rdata),
        .i_hi_rdata    (hi_rdata),
        .o_lo_re       (lo_re),
        .o_hi_re       (hi_re),
        .i_issue_ack   (i_issue_ack),
        .o_issue_valid (o_issue_valid),
        .o_issue_instr (o_issue_instr),
        .o_issue_ci    (o_issue_ci),
        .o_issue_err   (o_issue_err)
    );

endmodule

// ==== bench/fetch_mem_model.sv ====
`timescale 1ns/1ns

module fetch_mem_model #(
    parameter int IMG_HALVES = 512                           // halfwords in the image
) (
    input  logic                  i_clk,
    input  logic                  i_rstn,
    // request from the DUT
    input  logic                  i_req_re,                  // one-cycle read strobe
    input  fetch_pkg::addr_t      i_req_addr,                // word aligned
    // error word of the current test
    input  logic                  i_err_en,
    input  fetch_pkg::word_addr_t i_err_word,
    // response, changes on the falling edge
    output logic                  o_rsp_ack,
    output logic                  o_rsp_err,
    output fetch_pkg::instr_t     o_rsp_data
);

    import fetch_pkg::*;

    half_t      image [IMG_HALVES];                          // filled by the testbench
    logic       req_hit;                                     // request seen last rising edge
    word_addr_t req_word;
    word_addr_t cur_word;                                    // word being answered
    logic       busy;
    int         wait_cnt;                                    // falling edges left
    int         delay;

    initial begin
        o_rsp_ack  = 1'b0;
        o_rsp_err  = 1'b0;
        o_rsp_data = '0;
    end

    // ============================================================
    // request capture
    // ============================================================

    always @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            req_hit  <= 1'b0;
            req_word <= '0;
        end else begin
            req_hit <= i_req_re;
            if (i_req_re) begin
                req_word <= i_req_addr[31:2];
            end
        end
    end

    // drive one word, or an error pulse for the error word
    task automatic answer(input word_addr_t w);
        int word_idx;
        word_idx   = int'(w) % (IMG_HALVES / 2);             // image wraps around
        o_rsp_data = {image[2*word_idx+1], image[2*word_idx]};
        if (i_err_en && (w == i_err_word)) begin
            o_rsp_err = 1'b1;
        end else begin
            o_rsp_ack = 1'b1;
        end
    endtask

    // ============================================================
    // response with 1 to 3 cycles of latency
    // ============================================================

    always @(negedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            o_rsp_ack  = 1'b0;
            o_rsp_err  = 1'b0;
            o_rsp_data = '0;
            busy       = 1'b0;
            wait_cnt   = 0;
        end else begin
            o_rsp_ack = 1'b0;                                // pulses last one cycle
            o_rsp_err = 1'b0;
            if (req_hit) begin
                delay    = $urandom_range(3, 1);
                cur_word = req_word;
                if (delay == 1) begin
                    answer(cur_word);                        // seen on the next rising edge
                end else begin
                    busy     = 1'b1;
                    wait_cnt = delay - 1;
                end
            end else if (busy) begin
                wait_cnt = wait_cnt - 1;
                if (wait_cnt == 0) begin
                    busy = 1'b0;
                    answer(cur_word);
                end
            end
        end
    end

endmodule

// ==== bench/fetch_frontend_tb.sv ====
`timescale 1ns/1ns

module fetch_frontend_tb;

    import fetch_pkg::*;

    localparam addr_t BOOT_ADDR  = 32'h0000_0000;
    localparam int    IMG_HALVES = 512;                      // 1 KiB image
    localparam int    BOOT_HALVES = 128;                     // 0x000..0x0ff holds only 32-bit
    localparam int    NUM_ROWS   = 6;

    logic       i_clk;
    logic       i_rstn;
    logic       i_redirect;
    addr_t      i_redirect_pc;
    logic       i_issue_ack;
    logic       o_bus_req_re;
    addr_t      o_bus_req_addr;
    instr_t     i_bus_rsp_data;
    logic       i_bus_rsp_ack;
    logic       i_bus_rsp_err;
    logic       o_issue_valid;
    instr_t     o_issue_instr;
    logic       o_issue_ci;
    logic       o_issue_err;
    logic       err_en;                                      // error word active
    word_addr_t err_word;

    // test table
    string      row_name   [NUM_ROWS];
    addr_t      row_pc     [NUM_ROWS];                       // redirect target, boot for row 0
    int         row_count  [NUM_ROWS];                       // instructions to check
    logic       row_err_en [NUM_ROWS];
    word_addr_t row_err_wd [NUM_ROWS];
    int         row_stall  [NUM_ROWS];                       // max idle cycles before ack

    half_t      image [IMG_HALVES];                          // reference copy
    int         ref_h;                                       // walk position, halfword index
    string      cur_name;
    int         err_count = 0;
    int         check_count = 0;
    int         cycle_count = 0;
    int         cycle_limit = 0;

    fetch_frontend #(.BOOT_ADDR(BOOT_ADDR), .IPB_DEPTH(4)) uut (
        .i_clk (i_clk), .i_rstn (i_rstn),
        .i_redirect (i_redirect), .i_redirect_pc (i_redirect_pc),
        .o_bus_req_re (o_bus_req_re), .o_bus_req_addr (o_bus_req_addr),
        .i_bus_rsp_data (i_bus_rsp_data), .i_bus_rsp_ack (i_bus_rsp_ack),
        .i_bus_rsp_err (i_bus_rsp_err),
        .o_issue_valid (o_issue_valid), .o_issue_instr (o_issue_instr),
        .o_issue_ci (o_issue_ci), .o_issue_err (o_issue_err), .i_issue_ack (i_issue_ack)
    );

    fetch_mem_model #(.IMG_HALVES(IMG_HALVES)) u_mem (
        .i_clk (i_clk), .i_rstn (i_rstn),
        .i_req_re (o_bus_req_re), .i_req_addr (o_bus_req_addr),
        .i_err_en (err_en), .i_err_word (err_word),
        .o_rsp_ack (i_bus_rsp_ack), .o_rsp_err (i_bus_rsp_err), .o_rsp_data (i_bus_rsp_data)
    );

    initial begin
        i_clk = 1'b0;
        forever #20 i_clk = ~i_clk;                          // 40 ns period
    end

    // ============================================================
    // helpers
    // ============================================================

    task automatic set_row(input int r, input string name, input addr_t pc, input int n,
                           input logic een, input word_addr_t ew, input int stall);
        row_name[r]   = name;
        row_pc[r]     = pc;
        row_count[r]  = n;
        row_err_en[r] = een;
        row_err_wd[r] = ew;
        row_stall[r]  = stall;
    endtask

    // boot region holds 32-bit pairs, the rest a random mix
    task automatic build_image();
        half_t v;
        for (int h = 0; h < IMG_HALVES; h++) begin
            v = 16'(h * 32'h9e37 + 32'h1234);                // unique per halfword
            if (h < BOOT_HALVES) begin
                if (h % 2 == 0) begin
                    v[1:0] = 2'b11;
                end
            end else if ($urandom_range(2, 0) == 0) begin
                v[1:0] = 2'b11;                              // start of a 32-bit instruction
            end else if (v[1:0] == 2'b11) begin
                v[1] = 1'b0;                                 // force compressed
            end
            image[h]       = v;
            u_mem.image[h] = v;
        end
    endtask

    task automatic check_value(input string what, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
        check_count++;
        assert (act_v === exp_v) else begin
            $display("Error: %s %s expected %h actual %h", cur_name, what, exp_v, act_v);
            err_count++;
        end
    endtask

    // next instruction of the reference walk, 1 or 2 parcels
    task automatic next_expected(output instr_t e_instr, output logic e_ci, output logic e_err);
        half_t      p0;
        half_t      p1;
        word_addr_t w0;
        word_addr_t w1;
        p0    = image[ref_h % IMG_HALVES];
        w0    = ref_h >> 1;
        w1    = (ref_h + 1) >> 1;
        e_err = err_en && (w0 == err_word);
        if (p0[1:0] != 2'b11) begin
            e_instr = {16'h0000, p0};
            e_ci    = 1'b1;
            ref_h   = ref_h + 1;
        end else begin
            p1      = image[(ref_h + 1) % IMG_HALVES];
            e_instr = {p1, p0};
            e_ci    = 1'b0;
            e_err   = e_err || (err_en && (w1 == err_word));
            ref_h   = ref_h + 2;
        end
    endtask

    // ============================================================
    // test sequence
    // ============================================================

    initial begin : main_flow
        int     idle;
        int     row_errs;
        instr_t e_instr;
        logic   e_ci;
        logic   e_err;
        instr_t held;
        void'($urandom(84));
        i_rstn        = 1'b0;
        i_redirect    = 1'b0;
        i_redirect_pc = '0;
        i_issue_ack   = 1'b0;
        err_en        = 1'b0;
        err_word      = '0;
        cur_name      = "reset";
        set_row(0, "boot",       BOOT_ADDR, 20, 1'b0, 30'h0,   0);
        set_row(1, "mixed",      32'h100,   40, 1'b0, 30'h0,   1);
        set_row(2, "unaligned",  32'h1c6,   30, 1'b0, 30'h0,   2);
        set_row(3, "bus_error",  32'h200,   30, 1'b1, 30'h84,  1);
        set_row(4, "err_32bit",  32'h070,   10, 1'b1, 30'h1e,  0);
        set_row(5, "long_stall", 32'h282,   40, 1'b0, 30'h0,  12);
        cycle_limit = 200;
        for (int r = 0; r < NUM_ROWS; r++) begin
            cycle_limit += row_count[r] * (row_stall[r] + 12);
        end
        build_image();
        repeat (5) begin
            @(negedge i_clk);
            check_value("request in reset", 32'd0, o_bus_req_re);
            check_value("valid in reset", 32'd0, o_issue_valid);
        end
        i_rstn = 1'b1;
        while (!o_bus_req_re) @(negedge i_clk);              // first fetch after reset
        check_value("first request address", BOOT_ADDR, o_bus_req_addr);
        for (int r = 0; r < NUM_ROWS; r++) begin
            cur_name = row_name[r];
            row_errs = err_count;
            if (r != 0) begin
                // let a fetch go out so the redirect meets a pending response
                for (int w = 0; w < 8 && !o_bus_req_re; w++) begin
                    @(negedge i_clk);
                end
                if (o_bus_req_re) begin
                    @(negedge i_clk);
                end
            end
            err_en   = row_err_en[r];
            err_word = row_err_wd[r];
            if (r != 0) begin
                i_redirect    = 1'b1;                        // one-cycle pulse
                i_redirect_pc = row_pc[r];
                @(negedge i_clk);
                i_redirect    = 1'b0;
            end
            ref_h = row_pc[r][31:1];
            for (int k = 0; k < row_count[r]; k++) begin
                while (!o_issue_valid) @(negedge i_clk);
                held = o_issue_instr;
                idle = $urandom_range(row_stall[r], 0);
                repeat (idle) begin
                    @(negedge i_clk);
                    check_value("valid during stall", 32'd1, o_issue_valid);
                    check_value("instr during stall", held, o_issue_instr);
                end
                next_expected(e_instr, e_ci, e_err);
                check_value("instr", e_instr, o_issue_instr);
                check_value("ci", e_ci, o_issue_ci);
                check_value("err", e_err, o_issue_err);
                i_issue_ack = 1'b1;
                @(negedge i_clk);
                i_issue_ack = 1'b0;
            end
            $display("test %s: %0d instructions, %0d errors", cur_name, row_count[r],
                     err_count - row_errs);
        end
        $display("tests %0d, checks %0d, errors %0d", NUM_ROWS, check_count, err_count);
        if (err_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // ============================================================
    // run limit
    // ============================================================

    always @(posedge i_clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("run timed out after %0d cycles, tests did not finish", cycle_count);
            $display("ERRORS FOUND");
            $finish;
        end
    end

endmodule

// ==== fetch_frontend.f ====
hdl/fetch_pkg.sv
hdl/fetch_ctrl.sv
hdl/ipb_lane_fifo.sv
hdl/issue_align.sv
hdl/fetch_frontend.sv
bench/fetch_mem_model.sv
bench/fetch_frontend_tb.sv
